/* logic/ex_arith.sv */
`timescale 1ns/1ns

module ex_arith (
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::word_t   arith_res_o,
    output logic            ovf_o
);
    import ex_pkg::*;

    logic       is_sub;
    word_t      opnd2;
    word_t      sum;
    word_t      cnt_src;
    logic [5:0] lead_cnt;
    logic       lt_s;
    logic       lt_u;
    logic       sum_ovf;

    assign is_sub = (req_i.aluop == OP_SUB) || (req_i.aluop == OP_SUBU);

    // two's complement of operand 2 as inverse plus carry in
    assign opnd2 = is_sub ? ~req_i.reg2 : req_i.reg2;
    assign sum   = req_i.reg1 + opnd2 + {31'b0, is_sub};

    assign sum_ovf = (req_i.reg1[31] == opnd2[31]) && (sum[31] != req_i.reg1[31]);
    assign ovf_o   = sum_ovf && ((req_i.aluop == OP_ADD) || (req_i.aluop == OP_ADDI) ||
                                 (req_i.aluop == OP_SUB));

    assign lt_s = $signed(req_i.reg1) < $signed(req_i.reg2);
    assign lt_u = req_i.reg1 < req_i.reg2;

    // clo counts the leading zeros of the inverted operand
    assign cnt_src = (req_i.aluop == OP_CLO) ? ~req_i.reg1 : req_i.reg1;

    always_comb begin
        lead_cnt = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (cnt_src[i]) begin
                lead_cnt = 6'(31 - i);
            end
        end
    end

    always_comb begin
        case (req_i.aluop)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU,
            OP_SUB, OP_SUBU: arith_res_o = sum;
            OP_SLT:          arith_res_o = {31'b0, lt_s};
            OP_SLTU:         arith_res_o = {31'b0, lt_u};
            OP_CLZ, OP_CLO:  arith_res_o = {26'b0, lead_cnt};
            default:         arith_res_o = '0;
        endcase
    end

endmodule

/* logic/ex_logic_shift.sv */
`timescale 1ns/1ns

module ex_logic_shift (
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::word_t   logic_res_o,
    output ex_pkg::word_t   shift_res_o
);
    import ex_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = req_i.reg1[SHAMT_W-1:0];

    always_comb begin
        case (req_i.aluop)
            OP_OR:   logic_res_o = req_i.reg1 | req_i.reg2;
            OP_AND:  logic_res_o = req_i.reg1 & req_i.reg2;
            OP_XOR:  logic_res_o = req_i.reg1 ^ req_i.reg2;
            OP_NOR:  logic_res_o = ~(req_i.reg1 | req_i.reg2);
            default: logic_res_o = '0;
        endcase
    end

    // operand 2 is shifted, operand 1 gives the amount
    always_comb begin
        case (req_i.aluop)
            OP_SLL:  shift_res_o = req_i.reg2 << shamt;
            OP_SRL:  shift_res_o = req_i.reg2 >> shamt;
            OP_SRA:  shift_res_o = word_t'($signed(req_i.reg2) >>> shamt);
            default: shift_res_o = '0;
        endcase
    end

endmodule

/* logic/ex_mul.sv */
`timescale 1ns/1ns

module ex_mul (
    input  logic             clk,
    input  logic             rst_n_i,
    input  ex_pkg::ex_req_t  req_i,
    input  ex_pkg::dword_t   hilo_i,
    output ex_pkg::word_t    mul_lo_o,
    output ex_pkg::hilo_wr_t hilo_wr_o,
    output logic             stall_o
);
    import ex_pkg::*;

    logic   is_signed;
    logic   is_mac;
    logic   is_msub;
    logic   accepted;
    word_t  mag1;
    word_t  mag2;
    dword_t prod_mag;
    dword_t prod;
    dword_t mac_sum;
    logic   cnt;
    dword_t partial;

    assign is_signed = (req_i.aluop == OP_MULT) || (req_i.aluop == OP_MADD) ||
                       (req_i.aluop == OP_MSUB);
    assign is_msub   = (req_i.aluop == OP_MSUB) || (req_i.aluop == OP_MSUBU);
    assign is_mac    = is_msub || (req_i.aluop == OP_MADD) || (req_i.aluop == OP_MADDU);

    // multiply magnitudes, then restore the sign
    assign mag1     = (is_signed && req_i.reg1[31]) ? (~req_i.reg1 + 32'd1) : req_i.reg1;
    assign mag2     = (is_signed && req_i.reg2[31]) ? (~req_i.reg2 + 32'd1) : req_i.reg2;
    assign prod_mag = {32'b0, mag1} * {32'b0, mag2};
    assign prod     = (is_signed && (req_i.reg1[31] ^ req_i.reg2[31])) ?
                      (~prod_mag + 64'd1) : prod_mag;
    assign mul_lo_o = prod[31:0];

    // first cycle of madd/msub stalls
    assign stall_o  = req_i.valid && is_mac && !cnt;
    assign accepted = req_i.valid && !stall_o;
    assign mac_sum  = hilo_i + partial;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt <= 1'b0;
        end else begin
            cnt <= stall_o;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_o) begin
            partial <= is_msub ? (~prod + 64'd1) : prod;
        end
    end

    always_comb begin
        hilo_wr_o.we = 1'b0;
        hilo_wr_o.hi = hilo_i[63:32];
        hilo_wr_o.lo = hilo_i[31:0];
        case (req_i.aluop)
            OP_MULT, OP_MULTU: begin
                hilo_wr_o.we = accepted;
                {hilo_wr_o.hi, hilo_wr_o.lo} = prod;
            end
            OP_MTHI: begin
                hilo_wr_o.we = accepted;
                hilo_wr_o.hi = req_i.reg1;
            end
            OP_MTLO: begin
                hilo_wr_o.we = accepted;
                hilo_wr_o.lo = req_i.reg1;
            end
            OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: begin
                // only reached in the second cycle
                hilo_wr_o.we = accepted;
                {hilo_wr_o.hi, hilo_wr_o.lo} = mac_sum;
            end
            default: begin
                hilo_wr_o.we = 1'b0;
            end
        endcase
    end

endmodule

/* logic/ex_pkg.sv */
package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int SHAMT_W = 5;

    // opcode values follow the decode stage encoding
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_OR    = 8'b0010_0101,
        OP_AND   = 8'b0010_0100,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_ADDI  = 8'b0101_0101,
        OP_ADDIU = 8'b0101_0110,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011,
        OP_MTHI  = 8'b0001_0001,
        OP_MTLO  = 8'b0001_0011,
        OP_MFHI  = 8'b0001_0000,
        OP_MFLO  = 8'b0001_0010
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NONE  = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_e;

    typedef struct packed {
        logic      valid;
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
    } ex_req_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } ex_wb_t;

    typedef struct packed {
        logic  we;
        word_t hi;
        word_t lo;
    } hilo_wr_t;

endpackage

/* logic/ex_result_reg.sv */
`timescale 1ns/1ns

module ex_result_reg (
    input  logic            clk,
    input  logic            rst_n_i,
    input  ex_pkg::ex_req_t req_i,
    input  logic            stall_i,
    input  ex_pkg::word_t   logic_res_i,
    input  ex_pkg::word_t   shift_res_i,
    input  ex_pkg::word_t   arith_res_i,
    input  ex_pkg::word_t   mul_lo_i,
    input  logic            ovf_i,
    input  ex_pkg::dword_t  hilo_i,
    output ex_pkg::ex_wb_t  wb_o
);
    import ex_pkg::*;

    word_t wdata;
    word_t move_res;
    logic  wreg_next;

    always_comb begin
        case (req_i.aluop)
            OP_MFHI: move_res = hilo_i[63:32];
            OP_MFLO: move_res = hilo_i[31:0];
            default: move_res = '0;
        endcase
    end

    always_comb begin
        case (req_i.alusel)
            SEL_LOGIC: wdata = logic_res_i;
            SEL_SHIFT: wdata = shift_res_i;
            SEL_MOVE:  wdata = move_res;
            SEL_ARITH: wdata = arith_res_i;
            SEL_MUL:   wdata = mul_lo_i;
            default:   wdata = '0;
        endcase
    end

    // no register write on overflow or without an accepted request
    assign wreg_next = req_i.valid && !stall_i && req_i.wreg && !ovf_i;

    always_ff @(posedge clk) begin
        wb_o.wd    <= req_i.wd;
        wb_o.wdata <= wdata;
        if (!rst_n_i) begin
            wb_o.wreg <= 1'b0;
        end else begin
            wb_o.wreg <= wreg_next;
        end
    end

endmodule

/* logic/ex_top.sv */
`timescale 1ns/1ns

module ex_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  ex_pkg::ex_req_t  req_i,
    output ex_pkg::ex_wb_t   wb_o,
    output logic             stall_o
);
    import ex_pkg::*;

    word_t    logic_res;
    word_t    shift_res;
    word_t    arith_res;
    word_t    mul_lo;
    logic     ovf;
    dword_t   hilo;
    hilo_wr_t hilo_wr;

    ex_logic_shift u_logic_shift (
        .req_i       (req_i),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res)
    );

    ex_arith u_arith (
        .req_i       (req_i),
        .arith_res_o (arith_res),
        .ovf_o       (ovf)
    );

    ex_mul u_mul (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .hilo_i    (hilo),
        .mul_lo_o  (mul_lo),
        .hilo_wr_o (hilo_wr),
        .stall_o   (stall_o)
    );

    hilo_reg u_hilo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_i    (hilo_wr),
        .hilo_o  (hilo)
    );

    ex_result_reg u_result (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .stall_i     (stall_o),
        .logic_res_i (logic_res),
        .shift_res_i (shift_res),
        .arith_res_i (arith_res),
        .mul_lo_i    (mul_lo),
        .ovf_i       (ovf),
        .hilo_i      (hilo),
        .wb_o        (wb_o)
    );

endmodule

/* logic/hilo_reg.sv */
`timescale 1ns/1ns

module hilo_reg (
    input  logic             clk,
    input  logic             rst_n_i,
    input  ex_pkg::hilo_wr_t wr_i,
    output ex_pkg::dword_t   hilo_o
);

    // hi in the upper word, lo in the lower
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hilo_o <= '0;
        end else if (wr_i.we) begin
            hilo_o <= {wr_i.hi, wr_i.lo};
        end
    end

endmodule

/* project.f */
logic/ex_pkg.sv
logic/ex_logic_shift.sv
logic/ex_arith.sv
logic/ex_mul.sv
logic/hilo_reg.sv
logic/ex_result_reg.sv
logic/ex_top.sv
testbench/tb_clock.sv
testbench/ex_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ns --top-module ex_tb -f project.f \
    -o ex_tb_sim && ./obj_dir/ex_tb_sim || exit 1

/* testbench/ex_tb.sv */
`timescale 1ns/1ns

module ex_tb;
    import ex_pkg::*;

    localparam int N_ROUNDS = 8;
    // several times the cycles that all tests take together
    localparam int WATCHDOG_CYCLES = 10 * (N_ROUNDS * 20 + 40);

    logic    clk;
    logic    rst_n;
    logic    stall;
    ex_req_t req;
    ex_wb_t  wb;
    integer  seed;
    int      stall_cycles;
    word_t   a;
    word_t   b;

    tb_clock u_clock (.clk_o(clk), .rst_n_o(rst_n));
    ex_top dut_i (.clk(clk), .rst_n_i(rst_n), .req_i(req), .wb_o(wb), .stall_o(stall));

    task automatic check_eq(input string name, input dword_t exp, input dword_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "wrong value in %s", name);
        end
    endtask

    // drive one request, wait until accepted, then check the registered result
    task automatic issue(input string name, input aluop_e op, input alusel_e sel,
                         input word_t r1, input word_t r2, input logic wreg,
                         input logic wreg_exp, input word_t exp);
        logic stalled;
        req = '{valid: 1'b1, aluop: op, alusel: sel, reg1: r1, reg2: r2,
                wd: 5'($random(seed)), wreg: wreg};
        stall_cycles = 0;
        stalled = 1'b1;
        while (stalled) begin
            #1;
            stalled = stall;
            stall_cycles = stall_cycles + int'(stalled);
            @(posedge clk);
        end
        @(negedge clk);
        req.valid = 1'b0;
        check_eq({name, " wreg"}, 64'(wreg_exp), 64'(wb.wreg));
        check_eq({name, " wd"}, 64'(req.wd), 64'(wb.wd));
        if (wreg_exp) begin
            check_eq(name, 64'(exp), 64'(wb.wdata));
        end
    endtask

    task automatic check_hilo(input string name, input dword_t exp);
        issue({name, " mfhi"}, OP_MFHI, SEL_MOVE, '0, '0, 1'b1, 1'b1, exp[63:32]);
        issue({name, " mflo"}, OP_MFLO, SEL_MOVE, '0, '0, 1'b1, 1'b1, exp[31:0]);
    endtask

    function automatic word_t alu_model(input aluop_e op, input word_t x, input word_t y);
        case (op)
            OP_OR:           return x | y;
            OP_AND:          return x & y;
            OP_XOR:          return x ^ y;
            OP_NOR:          return ~(x | y);
            OP_SLL:          return y << x[4:0];
            OP_SRL:          return y >> x[4:0];
            // vacated upper bits take the sign
            OP_SRA:          return (y >> x[4:0]) | ({32{y[31]}} & ~(32'hffff_ffff >> x[4:0]));
            OP_ADD, OP_ADDU: return x + y;
            OP_SUB, OP_SUBU: return x - y;
            OP_SLT:          return 32'((x[31] != y[31]) ? x[31] : (x < y));
            OP_SLTU:         return 32'(x < y);
            default:         return '0;
        endcase
    endfunction

    // exact 33-bit signed result, overflow when it does not fit in 32 bits
    function automatic logic signed_ovf(input aluop_e op, input word_t x, input word_t y);
        logic signed [32:0] wide;
        wide = $signed({x[31], x}) +
               ((op == OP_SUB) ? -$signed({y[31], y}) : $signed({y[31], y}));
        return wide[32] != wide[31];
    endfunction

    function automatic dword_t product(input word_t x, input word_t y, input logic sgn);
        return sgn ? dword_t'($signed({{32{x[31]}}, x}) * $signed({{32{y[31]}}, y}))
                   : {32'b0, x} * {32'b0, y};
    endfunction

    task automatic reset_state();
        check_eq("reset wreg", '0, 64'(wb.wreg));
        check_eq("reset stall", '0, 64'(stall));
        check_hilo("reset", '0);
    endtask

    task automatic logic_shift_ops();
        aluop_e ops [7];
        ops = '{OP_OR, OP_AND, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA};
        for (int r = 0; r < N_ROUNDS; r++) begin
            a = $random(seed);
            b = $random(seed);
            for (int k = 0; k < 7; k++) begin
                issue(ops[k].name(), ops[k], (k < 4) ? SEL_LOGIC : SEL_SHIFT, a, b,
                      1'b1, 1'b1, alu_model(ops[k], a, b));
            end
        end
        // negative operand shifted by 0 and by 31
        issue("sra by 0", OP_SRA, SEL_SHIFT, 32'h0, 32'h8000_00f0, 1'b1, 1'b1, 32'h8000_00f0);
        issue("sra by 31", OP_SRA, SEL_SHIFT, 32'h1f, 32'h8000_0000, 1'b1, 1'b1, '1);
    endtask

    task automatic arith_ops();
        aluop_e ops [6];
        ops = '{OP_ADD, OP_SUB, OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU};
        issue("addu wrap", OP_ADDU, SEL_ARITH, 32'hffff_fff0, 32'h20, 1'b1, 1'b1, 32'h10);
        issue("subu wrap", OP_SUBU, SEL_ARITH, 32'h0, 32'h1, 1'b1, 1'b1, '1);
        issue("add ovf", OP_ADD, SEL_ARITH, 32'h7fff_ffff, 32'h1, 1'b1, 1'b0, '0);
        issue("sub ovf", OP_SUB, SEL_ARITH, 32'h8000_0000, 32'h1, 1'b1, 1'b0, '0);
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int k = 0; k < 6; k++) begin
                a = $random(seed);
                b = $random(seed);
                issue(ops[k].name(), ops[k], SEL_ARITH, a, b, 1'b1,
                      !((k < 2) && signed_ovf(ops[k], a, b)), alu_model(ops[k], a, b));
            end
        end
    endtask

    task automatic lead_count_ops();
        issue("clz zero", OP_CLZ, SEL_ARITH, '0, '0, 1'b1, 1'b1, 32'd32);
        issue("clo ones", OP_CLO, SEL_ARITH, '1, '0, 1'b1, 1'b1, 32'd32);
        // a single bit at position i leaves 31 - i bits above it
        for (int i = 0; i < 32; i++) begin
            a = 32'b1 << i;
            issue($sformatf("clz bit %0d", i), OP_CLZ, SEL_ARITH, a, '0, 1'b1, 1'b1, 32'(31 - i));
            issue($sformatf("clo bit %0d", i), OP_CLO, SEL_ARITH, ~a, '0, 1'b1, 1'b1, 32'(31 - i));
        end
    endtask

    task automatic hilo_ops();
        dword_t prod;
        a = $random(seed);
        b = $random(seed);
        issue("mthi", OP_MTHI, SEL_NONE, a, '0, 1'b0, 1'b0, '0);
        issue("mtlo", OP_MTLO, SEL_NONE, b, '0, 1'b0, 1'b0, '0);
        check_hilo("mthi mtlo", {a, b});
        for (int r = 0; r < N_ROUNDS; r++) begin
            a = $random(seed);
            b = $random(seed);
            prod = product(a, b, 1'b1);
            // low product word also reaches the result register
            issue("mult", OP_MULT, SEL_MUL, a, b, 1'b1, 1'b1, prod[31:0]);
            check_hilo("mult", prod);
            issue("multu", OP_MULTU, SEL_NONE, a, b, 1'b0, 1'b0, '0);
            check_hilo("multu", product(a, b, 1'b0));
        end
    endtask

    task automatic mac_ops();
        aluop_e ops [4];
        dword_t base;
        dword_t prod;
        ops = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int k = 0; k < 4; k++) begin
                a    = $random(seed);
                b    = $random(seed);
                base = {32'($random(seed)), 32'($random(seed))};
                prod = product(a, b, (ops[k] == OP_MADD) || (ops[k] == OP_MSUB));
                issue("mac mthi", OP_MTHI, SEL_NONE, base[63:32], '0, 1'b0, 1'b0, '0);
                issue("mac mtlo", OP_MTLO, SEL_NONE, base[31:0], '0, 1'b0, 1'b0, '0);
                issue(ops[k].name(), ops[k], SEL_MUL, a, b, 1'b0, 1'b0, '0);
                check_eq({ops[k].name(), " stall cycles"}, 64'd1, 64'(stall_cycles));
                check_hilo(ops[k].name(), (k < 2) ? base + prod : base - prod);
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, the DUT stopped accepting requests");
        $display("Simulation failed");
        $fatal(1, "timeout after %0d cycles", WATCHDOG_CYCLES);
    end

    initial begin
        seed = 32'hecbcf199;
        // write request held through reset so that only the reset clears wreg and HI
        req  = '{valid: 1'b1, aluop: OP_MTHI, alusel: SEL_NONE, reg1: '1, reg2: '0,
                 wd: '0, wreg: 1'b1};
        @(posedge rst_n);
        reset_state();
        logic_shift_ops();
        arith_ops();
        lead_count_ops();
        hilo_ops();
        mac_ops();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);
    localparam int PERIOD_NS  = 100;
    localparam int RST_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule
